/* Makefile */
# Verilator build and run for the morphology pipeline

VERILATOR ?= verilator
TOP       ?= morphTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sim.f
VFLAGS    ?= --binary -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := verification/morphModel.svh
SIMBIN  := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIMBIN)

$(SIMBIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Run ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* common/morphPkg.sv */
package morphPkg;

    ////////////////////////////////////////////////////////////
    // Raster counter widths
    ////////////////////////////////////////////////////////////

    localparam int HCNT_W = 12;
    localparam int VCNT_W = 11;

    ////////////////////////////////////////////////////////////
    // Frame defaults
    ////////////////////////////////////////////////////////////

    // Active picture size in pixels and lines
    localparam int DEF_ACT_W = 320;
    localparam int DEF_ACT_H = 240;

    // Blanking after each line and after each frame
    localparam int DEF_H_BLANK = 8;
    localparam int DEF_V_BLANK = 2;

    ////////////////////////////////////////////////////////////
    // Operation and mode encodings
    ////////////////////////////////////////////////////////////

    // What a single 3x3 stage does
    typedef enum logic [1:0] {
        OP_PASS   = 2'd0,
        OP_ERODE  = 2'd1,
        OP_DILATE = 2'd2
    } morphOp_e;

    // Whole-pipeline mode, sampled once per frame
    typedef enum logic [1:0] {
        MODE_PASS  = 2'd0,
        MODE_OPEN  = 2'd1,
        MODE_CLOSE = 2'd2
    } pipeMode_e;

endpackage

/* logic/binarizer.sv */
`timescale 1ns/1ps

module binarizer (
    input  logic                        PCLK,
    input  logic                        reset_i,
    input  logic [7:0]                  luma_i,
    input  logic [7:0]                  threshold_i,
    input  logic [morphPkg::HCNT_W-1:0] hCnt_i,
    input  logic [morphPkg::VCNT_W-1:0] vCnt_i,
    input  logic                        active_i,
    output logic                        bit_o,
    output logic [morphPkg::HCNT_W-1:0] hCnt_o,
    output logic [morphPkg::VCNT_W-1:0] vCnt_o,
    output logic                        valid_o
);

    // Threshold decision, forced low in blanking
    always_ff @(posedge PCLK) begin
        if (reset_i) begin
            bit_o   <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            bit_o   <= active_i && (luma_i >= threshold_i);
            valid_o <= active_i;
        end
    end

    // Coordinate travels with the bit
    always_ff @(posedge PCLK) begin
        hCnt_o <= hCnt_i;
        vCnt_o <= vCnt_i;
    end

endmodule

/* logic/morphPipeline.sv */
`timescale 1ns/1ps

module morphPipeline #(
    parameter int ACT_W   = morphPkg::DEF_ACT_W,
    parameter int ACT_H   = morphPkg::DEF_ACT_H,
    parameter int H_BLANK = morphPkg::DEF_H_BLANK,
    parameter int V_BLANK = morphPkg::DEF_V_BLANK
) (
    input  logic                        PCLK,
    input  logic                        reset_i,
    input  logic [7:0]                  luma_i,
    input  logic [7:0]                  threshold_i,
    input  morphPkg::pipeMode_e         mode_i,
    output logic [morphPkg::HCNT_W-1:0] hCnt_o,
    output logic [morphPkg::VCNT_W-1:0] vCnt_o,
    output logic                        pixel_o,
    output logic [morphPkg::HCNT_W-1:0] outHCnt_o,
    output logic [morphPkg::VCNT_W-1:0] outVCnt_o,
    output logic                        outValid_o
);
    import morphPkg::*;

    logic              active;
    logic              frameStart;
    logic [7:0]        thrLatch;
    logic [7:0]        thrUse;
    pipeMode_e         modeLatch;
    morphOp_e          op1;
    morphOp_e          op2;
    logic              binBit;
    logic [HCNT_W-1:0] binHCnt;
    logic [VCNT_W-1:0] binVCnt;
    logic              binValid;
    logic              s1Bit;
    logic [HCNT_W-1:0] s1HCnt;
    logic [VCNT_W-1:0] s1VCnt;
    logic              s1Valid;

    videoTiming #(
        .ACT_W   (ACT_W),
        .ACT_H   (ACT_H),
        .H_BLANK (H_BLANK),
        .V_BLANK (V_BLANK)
    ) timing (
        .PCLK         (PCLK),
        .reset_i      (reset_i),
        .hCnt_o       (hCnt_o),
        .vCnt_o       (vCnt_o),
        .active_o     (active),
        .frameStart_o (frameStart)
    );

    ////////////////////////////////////////////////////////////
    // Per-frame settings
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (reset_i) begin
            modeLatch <= MODE_PASS;
        end else if (frameStart) begin
            modeLatch <= mode_i;
        end
    end

    always_ff @(posedge PCLK) begin
        if (frameStart) begin
            thrLatch <= threshold_i;
        end
    end

    // Pixel (0,0) is sampled in the latch cycle itself
    assign thrUse = frameStart ? threshold_i : thrLatch;

    always_comb begin
        case (modeLatch)
            MODE_OPEN: begin
                op1 = OP_ERODE;
                op2 = OP_DILATE;
            end
            MODE_CLOSE: begin
                op1 = OP_DILATE;
                op2 = OP_ERODE;
            end
            default: begin
                op1 = OP_PASS;
                op2 = OP_PASS;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pixel path
    ////////////////////////////////////////////////////////////

    binarizer binarize (
        .PCLK        (PCLK),
        .reset_i     (reset_i),
        .luma_i      (luma_i),
        .threshold_i (thrUse),
        .hCnt_i      (hCnt_o),
        .vCnt_i      (vCnt_o),
        .active_i    (active),
        .bit_o       (binBit),
        .hCnt_o      (binHCnt),
        .vCnt_o      (binVCnt),
        .valid_o     (binValid)
    );

    morphStage #(
        .ACT_W (ACT_W),
        .ACT_H (ACT_H)
    ) stage1 (
        .PCLK    (PCLK),
        .reset_i (reset_i),
        .op_i    (op1),
        .bit_i   (binBit),
        .hCnt_i  (binHCnt),
        .vCnt_i  (binVCnt),
        .valid_i (binValid),
        .bit_o   (s1Bit),
        .hCnt_o  (s1HCnt),
        .vCnt_o  (s1VCnt),
        .valid_o (s1Valid)
    );

    // Second stage sees the centre coordinates of the first
    morphStage #(
        .ACT_W (ACT_W),
        .ACT_H (ACT_H)
    ) stage2 (
        .PCLK    (PCLK),
        .reset_i (reset_i),
        .op_i    (op2),
        .bit_i   (s1Bit),
        .hCnt_i  (s1HCnt),
        .vCnt_i  (s1VCnt),
        .valid_i (s1Valid),
        .bit_o   (pixel_o),
        .hCnt_o  (outHCnt_o),
        .vCnt_o  (outVCnt_o),
        .valid_o (outValid_o)
    );

endmodule

/* logic/videoTiming.sv */
`timescale 1ns/1ps

module videoTiming #(
    parameter int ACT_W   = morphPkg::DEF_ACT_W,
    parameter int ACT_H   = morphPkg::DEF_ACT_H,
    parameter int H_BLANK = morphPkg::DEF_H_BLANK,
    parameter int V_BLANK = morphPkg::DEF_V_BLANK
) (
    input  logic                        PCLK,
    input  logic                        reset_i,
    output logic [morphPkg::HCNT_W-1:0] hCnt_o,
    output logic [morphPkg::VCNT_W-1:0] vCnt_o,
    output logic                        active_o,
    output logic                        frameStart_o
);
    import morphPkg::*;

    // Last count of a line and of a frame, blanking included
    localparam logic [HCNT_W-1:0] H_LAST = HCNT_W'(ACT_W + H_BLANK - 1);
    localparam logic [VCNT_W-1:0] V_LAST = VCNT_W'(ACT_H + V_BLANK - 1);

    // Active area bounds
    localparam logic [HCNT_W-1:0] H_ACT = HCNT_W'(ACT_W);
    localparam logic [VCNT_W-1:0] V_ACT = VCNT_W'(ACT_H);

    ////////////////////////////////////////////////////////////
    // Raster counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (reset_i) begin
            hCnt_o <= '0;
            vCnt_o <= '0;
        end else if (hCnt_o == H_LAST) begin
            hCnt_o <= '0;
            // Line wrap also steps the line counter
            if (vCnt_o == V_LAST) begin
                vCnt_o <= '0;
            end else begin
                vCnt_o <= vCnt_o + 1'b1;
            end
        end else begin
            hCnt_o <= hCnt_o + 1'b1;
        end
    end

    // Decoded from the counters
    assign active_o     = (hCnt_o < H_ACT) && (vCnt_o < V_ACT);
    assign frameStart_o = (hCnt_o == '0) && (vCnt_o == '0);

endmodule

/* morph/morphStage.sv */
`timescale 1ns/1ps

module morphStage #(
    parameter int ACT_W = morphPkg::DEF_ACT_W,
    parameter int ACT_H = morphPkg::DEF_ACT_H
) (
    input  logic                        PCLK,
    input  logic                        reset_i,
    input  morphPkg::morphOp_e          op_i,
    input  logic                        bit_i,
    input  logic [morphPkg::HCNT_W-1:0] hCnt_i,
    input  logic [morphPkg::VCNT_W-1:0] vCnt_i,
    input  logic                        valid_i,
    output logic                        bit_o,
    output logic [morphPkg::HCNT_W-1:0] hCnt_o,
    output logic [morphPkg::VCNT_W-1:0] vCnt_o,
    output logic                        valid_o
);
    import morphPkg::*;

    // Input positions whose centre sits on the picture edge
    localparam logic [HCNT_W-1:0] H_ONE = HCNT_W'(1);
    localparam logic [HCNT_W-1:0] H_ACT = HCNT_W'(ACT_W);
    localparam logic [VCNT_W-1:0] V_ONE = VCNT_W'(1);
    localparam logic [VCNT_W-1:0] V_ACT = VCNT_W'(ACT_H);

    logic [8:0] win;
    logic       centreIn;
    logic       border;
    logic       result;

    morphWindow #(
        .ACT_W (ACT_W),
        .ACT_H (ACT_H)
    ) window (
        .PCLK    (PCLK),
        .reset_i (reset_i),
        .bit_i   (bit_i),
        .hCnt_i  (hCnt_i),
        .vCnt_i  (vCnt_i),
        .valid_i (valid_i),
        .win_o   (win)
    );

    ////////////////////////////////////////////////////////////
    // Centre position
    ////////////////////////////////////////////////////////////

    // Centre is one pixel left and one line up
    assign centreIn = (hCnt_i >= H_ONE) && (hCnt_i <= H_ACT) &&
                      (vCnt_i >= V_ONE) && (vCnt_i <= V_ACT);

    assign border = (hCnt_i == H_ONE) || (hCnt_i == H_ACT) ||
                    (vCnt_i == V_ONE) || (vCnt_i == V_ACT);

    always_comb begin
        case (op_i)
            OP_ERODE:  result = (&win) & ~border;
            OP_DILATE: result = (|win) & ~border;
            // Pass keeps the edge pixels too
            default:   result = win[4];
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK) begin
        if (reset_i) begin
            bit_o   <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            bit_o   <= centreIn & result;
            valid_o <= centreIn;
        end
    end

    // Wraps below zero, which lands outside the picture
    always_ff @(posedge PCLK) begin
        hCnt_o <= hCnt_i - 1'b1;
        vCnt_o <= vCnt_i - 1'b1;
    end

endmodule

/* morph/morphWindow.sv */
`timescale 1ns/1ps

module morphWindow #(
    parameter int ACT_W = morphPkg::DEF_ACT_W,
    parameter int ACT_H = morphPkg::DEF_ACT_H
) (
    input  logic                        PCLK,
    input  logic                        reset_i,
    input  logic                        bit_i,
    input  logic [morphPkg::HCNT_W-1:0] hCnt_i,
    input  logic [morphPkg::VCNT_W-1:0] vCnt_i,
    input  logic                        valid_i,
    output logic [8:0]                  win_o
);
    import morphPkg::*;

    localparam int AW = (ACT_W > 1) ? $clog2(ACT_W) : 1;

    localparam logic [HCNT_W-1:0] H_ACT  = HCNT_W'(ACT_W);
    localparam logic [HCNT_W-1:0] H_END  = HCNT_W'(ACT_W - 1);
    localparam logic [VCNT_W-1:0] V_ONE  = VCNT_W'(1);
    localparam logic [VCNT_W-1:0] V_ACT  = VCNT_W'(ACT_H);
    localparam logic [VCNT_W-1:0] V_ACT1 = VCNT_W'(ACT_H + 1);

    // One bit per pixel, three lines deep
    logic lineBuf [3][ACT_W];

    logic [1:0]    rowIdx;
    logic [1:0]    curIdx;
    logic [1:0]    prevIdx;
    logic [1:0]    oldIdx;
    logic [AW-1:0] addr;
    logic          colIn;
    logic          rowOk1;
    logic          rowOk2;
    logic          newBit;
    logic          rdPrev;
    logic          rdOld;
    logic [1:0]    srCur;
    logic [1:0]    srPrev;
    logic [1:0]    srOld;

    ////////////////////////////////////////////////////////////
    // Line buffer rotation
    ////////////////////////////////////////////////////////////

    // Row 0 always lands in buffer 0
    assign curIdx = (vCnt_i == '0) ? 2'd0 : rowIdx;

    always_comb begin
        case (curIdx)
            2'd0:    begin prevIdx = 2'd2; oldIdx = 2'd1; end
            2'd1:    begin prevIdx = 2'd0; oldIdx = 2'd2; end
            default: begin prevIdx = 2'd1; oldIdx = 2'd0; end
        endcase
    end

    // Step after the last active pixel of a line
    always_ff @(posedge PCLK) begin
        if (reset_i) begin
            rowIdx <= 2'd0;
        end else if (valid_i && (hCnt_i == H_END)) begin
            rowIdx <= (curIdx == 2'd2) ? 2'd0 : curIdx + 2'd1;
        end
    end

    assign addr = hCnt_i[AW-1:0];

    always_ff @(posedge PCLK) begin
        if (valid_i) begin
            lineBuf[curIdx][addr] <= bit_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Neighbourhood taps
    ////////////////////////////////////////////////////////////

    // Outside the picture everything reads as background
    assign colIn  = hCnt_i < H_ACT;
    assign rowOk1 = (vCnt_i != '0) && (vCnt_i <= V_ACT);
    assign rowOk2 = (vCnt_i > V_ONE) && (vCnt_i <= V_ACT1);

    assign newBit = bit_i & valid_i;
    assign rdPrev = (colIn && rowOk1) ? lineBuf[prevIdx][addr] : 1'b0;
    assign rdOld  = (colIn && rowOk2) ? lineBuf[oldIdx][addr] : 1'b0;

    // Columns x-1 and x-2 of each row
    always_ff @(posedge PCLK) begin
        srCur  <= {srCur[0], newBit};
        srPrev <= {srPrev[0], rdPrev};
        srOld  <= {srOld[0], rdOld};
    end

    // Rows top to bottom, each as {x, x-1, x-2}; centre is bit 4
    assign win_o = {rdOld,  srOld[0],  srOld[1],
                    rdPrev, srPrev[0], srPrev[1],
                    newBit, srCur[0],  srCur[1]};

endmodule

/* sim.f */
common/morphPkg.sv
logic/videoTiming.sv
logic/binarizer.sv
morph/morphWindow.sv
morph/morphStage.sv
logic/morphPipeline.sv
+incdir+verification
verification/morphTb.sv

/* verification/morphModel.svh */
`ifndef MORPH_MODEL_SVH
`define MORPH_MODEL_SVH

// Whole frames held as packed arrays, indexed [line][pixel]
typedef logic [TB_H-1:0][TB_W-1:0]      bitFrame_t;
typedef logic [TB_H-1:0][TB_W-1:0][7:0] lumaFrame_t;

////////////////////////////////////////////////////////////
// Golden frame model
////////////////////////////////////////////////////////////

// A pixel is set when its luma reaches the threshold
function automatic bitFrame_t thresholdFrame(lumaFrame_t luma, logic [7:0] thr);
    bitFrame_t img;
    img = '0;
    for (int y = 0; y < TB_H; y++) begin
        for (int x = 0; x < TB_W; x++) begin
            img[y][x] = (luma[y][x] >= thr);
        end
    end
    return img;
endfunction

// One 3x3 stage; edge centres are cleared unless passing
function automatic bitFrame_t applyOp(bitFrame_t src, morphOp_e op);
    bitFrame_t dst;
    logic      allOne;
    logic      anyOne;
    dst = '0;
    for (int y = 0; y < TB_H; y++) begin
        for (int x = 0; x < TB_W; x++) begin
            if (op == OP_PASS) begin
                dst[y][x] = src[y][x];
            end else if (x == 0 || y == 0 || x == TB_W - 1 || y == TB_H - 1) begin
                dst[y][x] = 1'b0;
            end else begin
                allOne = 1'b1;
                anyOne = 1'b0;
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        allOne = allOne & src[y + dy][x + dx];
                        anyOne = anyOne | src[y + dy][x + dx];
                    end
                end
                dst[y][x] = (op == OP_ERODE) ? allOne : anyOne;
            end
        end
    end
    return dst;
endfunction

// Full pipeline result for one frame
function automatic bitFrame_t expectedFrame(lumaFrame_t luma, logic [7:0] thr,
                                            pipeMode_e mode);
    bitFrame_t bin;
    bin = thresholdFrame(luma, thr);
    case (mode)
        MODE_OPEN:  return applyOp(applyOp(bin, OP_ERODE), OP_DILATE);
        MODE_CLOSE: return applyOp(applyOp(bin, OP_DILATE), OP_ERODE);
        default:    return bin;
    endcase
endfunction

`endif

/* verification/morphTb.sv */
`timescale 1ns/1ps

module morphTb;
    import morphPkg::*;

    localparam int TB_W       = 16;
    localparam int TB_H       = 12;
    localparam int TB_HB      = 4;
    localparam int TB_VB      = 2;
    localparam int FRAME_CYC  = (TB_W + TB_HB) * (TB_H + TB_VB);
    localparam int CLK_NS     = 40;
    localparam int MAX_FRAMES = 16;
    localparam int ROWS       = 8;

    // Pattern kinds
    localparam int PAT_RANDOM = 0;
    localparam int PAT_DOTS   = 1;
    localparam int PAT_HOLES  = 2;
    localparam int PAT_FULL   = 3;

    `include "morphModel.svh"

    ////////////////////////////////////////////////////////////
    // Stimulus table: mode, threshold, pattern, frames
    ////////////////////////////////////////////////////////////

    localparam pipeMode_e TBL_MODE [ROWS] = '{MODE_PASS, MODE_OPEN, MODE_OPEN, MODE_CLOSE,
                                             MODE_CLOSE, MODE_OPEN, MODE_PASS, MODE_CLOSE};
    localparam logic [7:0] TBL_THR [ROWS] = '{8'd128, 8'd100, 8'd128, 8'd128,
                                             8'd100, 8'd128, 8'd60, 8'd128};
    localparam int TBL_PAT [ROWS]    = '{PAT_RANDOM, PAT_DOTS, PAT_HOLES, PAT_HOLES,
                                        PAT_DOTS, PAT_FULL, PAT_RANDOM, PAT_RANDOM};
    localparam int TBL_FRAMES [ROWS] = '{2, 1, 1, 1, 1, 1, 1, 1};

    logic              PCLK;
    logic              reset_i;
    logic [7:0]        luma_i;
    logic [7:0]        threshold_i;
    pipeMode_e         mode_i;
    logic [HCNT_W-1:0] hCnt_o;
    logic [VCNT_W-1:0] vCnt_o;
    logic              pixel_o;
    logic [HCNT_W-1:0] outHCnt_o;
    logic [VCNT_W-1:0] outVCnt_o;
    logic              outValid_o;

    lumaFrame_t frameLuma [MAX_FRAMES];
    bitFrame_t  frameExp  [MAX_FRAMES];
    pipeMode_e  frameMode [MAX_FRAMES];
    logic [7:0] frameThr  [MAX_FRAMES];
    int         totalFrames = 0;

    int errPixel = 0;
    int errCoord = 0;
    int errMode  = 0;
    int errOther = 0;
    int outCount = 0;
    int outFrame = 0;
    int expX     = 0;
    int expY     = 0;

    morphPipeline #(
        .ACT_W   (TB_W),
        .ACT_H   (TB_H),
        .H_BLANK (TB_HB),
        .V_BLANK (TB_VB)
    ) DUT (
        .PCLK        (PCLK),
        .reset_i     (reset_i),
        .luma_i      (luma_i),
        .threshold_i (threshold_i),
        .mode_i      (mode_i),
        .hCnt_o      (hCnt_o),
        .vCnt_o      (vCnt_o),
        .pixel_o     (pixel_o),
        .outHCnt_o   (outHCnt_o),
        .outVCnt_o   (outVCnt_o),
        .outValid_o  (outValid_o)
    );

    initial begin
        PCLK = 1'b0;
        forever #(CLK_NS / 2) PCLK = ~PCLK;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkPixel(logic got, logic exp, int x, int y);
        if (got !== exp) begin
            errPixel++;
            $display("ERROR @%0t: pixel (%0d,%0d) got %0b expected %0b", $time, x, y, got, exp);
        end
    endtask

    task automatic checkCoord(logic [HCNT_W-1:0] gotH, logic [VCNT_W-1:0] gotV,
                              logic [HCNT_W-1:0] expH, logic [VCNT_W-1:0] expV);
        if (gotH !== expH || gotV !== expV) begin
            errCoord++;
            $display("ERROR @%0t: coordinate (%0d,%0d) expected (%0d,%0d)",
                     $time, gotH, gotV, expH, expV);
        end
    endtask

    task automatic checkMode(pipeMode_e got, pipeMode_e exp);
        if (got !== exp) begin
            errMode++;
            $display("ERROR @%0t: mode in effect %s expected %s", $time, got.name(), exp.name());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Pattern generation
    ////////////////////////////////////////////////////////////

    function automatic lumaFrame_t makePattern(int kind);
        lumaFrame_t l;
        for (int y = 0; y < TB_H; y++) begin
            for (int x = 0; x < TB_W; x++) begin
                case (kind)
                    PAT_RANDOM: l[y][x] = 8'($urandom);
                    // Single bright pixels on a sparse grid
                    PAT_DOTS:   l[y][x] = (x % 4 == 2 && y % 3 == 1) ? 8'd200 : 8'd20;
                    PAT_HOLES: begin
                        l[y][x] = (x >= 2 && x <= 12 && y >= 2 && y <= 9) ? 8'd220 : 8'd30;
                        if ((x == 5 && y == 4) || (x == 9 && y == 6)) l[y][x] = 8'd10;
                    end
                    default:    l[y][x] = 8'd255;
                endcase
            end
        end
        return l;
    endfunction

    task automatic buildFrames();
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < TBL_FRAMES[r]; k++) begin
                frameLuma[totalFrames] = makePattern(TBL_PAT[r]);
                frameMode[totalFrames] = TBL_MODE[r];
                frameThr[totalFrames]  = TBL_THR[r];
                frameExp[totalFrames]  = expectedFrame(frameLuma[totalFrames],
                                                       TBL_THR[r], TBL_MODE[r]);
                totalFrames++;
            end
        end
    endtask

    // Drives one frame after another, indexed by the DUT counters
    task automatic driveFrames();
        int f;
        f = -1;
        while (1) begin
            if (hCnt_o == '0 && vCnt_o == '0) f++;
            if (f >= totalFrames) break;
            if (int'(hCnt_o) < TB_W && int'(vCnt_o) < TB_H) begin
                luma_i = frameLuma[f][vCnt_o][hCnt_o];
            end else begin
                luma_i = 8'($urandom);
            end
            // Next frame's settings arrive mid-frame
            if (int'(vCnt_o) == TB_H / 2 && hCnt_o == '0 && f + 1 < totalFrames) begin
                mode_i      = frameMode[f + 1];
                threshold_i = frameThr[f + 1];
            end
            @(negedge PCLK);
        end
        luma_i = 8'h00;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge PCLK) begin
        if (reset_i) begin
            if (outValid_o || pixel_o) begin
                errOther++;
                $display("Output valid or pixel high while reset is held");
            end
        end else if (outValid_o) begin
            if (outFrame >= totalFrames) begin
                errOther++;
                $display("Output pixel seen after the last frame");
            end else begin
                checkCoord(outHCnt_o, outVCnt_o, HCNT_W'(expX), VCNT_W'(expY));
                checkMode(DUT.modeLatch, frameMode[outFrame]);
                checkPixel(pixel_o, frameExp[outFrame][expY][expX], expX, expY);
            end
            outCount++;
            expX++;
            if (expX == TB_W) begin
                expX = 0;
                expY++;
                if (expY == TB_H) begin
                    expY = 0;
                    outFrame++;
                end
            end
        end
    end

    // Watchdog sized from the table
    initial begin
        int frames;
        frames = 0;
        for (int r = 0; r < ROWS; r++) frames += TBL_FRAMES[r];
        #((frames * FRAME_CYC * CLK_NS * 2) + 10 * CLK_NS);
        $display("Timeout: the run did not finish in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hd96c657f));
        reset_i     = 1'b1;
        luma_i      = 8'h00;
        threshold_i = 8'h00;
        mode_i      = MODE_PASS;
        buildFrames();
        mode_i      = frameMode[0];
        threshold_i = frameThr[0];
        repeat (5) @(posedge PCLK);
        @(negedge PCLK);
        reset_i = 1'b0;
        checkCoord(hCnt_o, vCnt_o, '0, '0);
        driveFrames();
        repeat (10) @(negedge PCLK);
        if (outCount != totalFrames * TB_W * TB_H) begin
            errOther++;
            $display("Got %0d output pixels, expected %0d", outCount, totalFrames * TB_W * TB_H);
        end
        $display("Errors: pixel %0d, coordinate %0d, mode %0d, other %0d",
                 errPixel, errCoord, errMode, errOther);
        if (errPixel + errCoord + errMode + errOther == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
